// ==== csr_defs.svh ====
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Data width of the core
`define XLEN 32

// Width of a CSR address and of an exception code
`define CSR_ADDR_W 12
`define CAUSE_W    5

// Machine CSR addresses that this unit implements
`define CSR_MSTATUS  12'h300
`define CSR_MIE      12'h304
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MIP      12'h344
`define CSR_MHARTID  12'hF14

// Bit positions inside mstatus
`define MSTATUS_UIE    0
`define MSTATUS_SIE    1
`define MSTATUS_MIE    3
`define MSTATUS_UPIE   4
`define MSTATUS_SPIE   5
`define MSTATUS_MPIE   7
`define MSTATUS_SPP    8
`define MSTATUS_MPP_LO 11

// External interrupt bit, same position in mie and mip
`define MIE_MEIE 11

// Exception and interrupt codes written to mcause
`define CAUSE_ILLEGAL_INSN 2
`define CAUSE_M_EXT_IRQ    11

`endif

// ==== csr_pkg.sv ====
`default_nettype none

`include "csr_defs.svh"

package csr_pkg;

    // One data word of the core
    typedef logic [`XLEN-1:0] xlen_t;

    // Address field of a CSR instruction
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // Exception code as it sits in the low bits of mcause
    typedef logic [`CAUSE_W-1:0] cause_t;

    // Only M and U exist, so the two reserved encodings never appear
    typedef enum logic [1:0] {
        priv_u = 2'b00,
        priv_m = 2'b11
    } priv_t;

    // Encoded like the low two bits of funct3 of CSRRW, CSRRS and CSRRC
    typedef enum logic [1:0] {
        csr_write = 2'b01,
        csr_set   = 2'b10,
        csr_clear = 2'b11
    } csr_op_t;

endpackage

`default_nettype wire

// ==== mstatus_reg.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "csr_defs.svh"

module mstatus_reg import csr_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  wr_mstatus,
    input  xlen_t wr_data,
    input  logic  trap_enter,
    input  logic  do_mret,
    output priv_t priv_mode,
    output xlen_t mstatus
);

    // Current privilege mode of the hart
    priv_t cur_mode;

    // Global interrupt enables
    logic st_mie;
    logic st_sie;
    logic st_uie;

    // Interrupt enables saved on trap entry
    logic st_mpie;
    logic st_spie;
    logic st_upie;

    // Privilege mode saved on trap entry
    priv_t st_mpp;
    logic  st_spp;

    // MPP field of an incoming write
    logic [1:0] new_mpp;
    logic       mpp_legal;

    assign new_mpp = wr_data[`MSTATUS_MPP_LO +: 2];

    // MPP is WARL and accepts only the U and M encodings
    assign mpp_legal = (new_mpp == 2'b00) || (new_mpp == 2'b11);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_mode <= priv_m;
            st_mie   <= 1'b0;
            st_sie   <= 1'b0;
            st_uie   <= 1'b0;
            st_mpie  <= 1'b0;
            st_spie  <= 1'b0;
            st_upie  <= 1'b0;
            st_mpp   <= priv_u;
            st_spp   <= 1'b0;
        end else if (trap_enter) begin
            // Every trap lands in M, so only the M fields move
            st_mpie  <= st_mie;
            st_mie   <= 1'b0;
            st_mpp   <= cur_mode;
            cur_mode <= priv_m;
        end else if (do_mret) begin
            cur_mode <= st_mpp;
            st_mie   <= st_mpie;
            st_mpie  <= 1'b1;
            st_mpp   <= priv_u;
        end else if (wr_mstatus) begin
            st_mie  <= wr_data[`MSTATUS_MIE];
            st_sie  <= wr_data[`MSTATUS_SIE];
            st_uie  <= wr_data[`MSTATUS_UIE];
            st_mpie <= wr_data[`MSTATUS_MPIE];
            st_spie <= wr_data[`MSTATUS_SPIE];
            st_upie <= wr_data[`MSTATUS_UPIE];
            st_spp  <= wr_data[`MSTATUS_SPP];
            // An illegal MPP leaves the old value in place
            if (mpp_legal) begin
                st_mpp <= priv_t'(new_mpp);
            end
        end
    end

    // Fields without storage read as zero
    always_comb begin
        mstatus = '0;
        mstatus[`MSTATUS_UIE]        = st_uie;
        mstatus[`MSTATUS_SIE]        = st_sie;
        mstatus[`MSTATUS_MIE]        = st_mie;
        mstatus[`MSTATUS_UPIE]       = st_upie;
        mstatus[`MSTATUS_SPIE]       = st_spie;
        mstatus[`MSTATUS_MPIE]       = st_mpie;
        mstatus[`MSTATUS_SPP]        = st_spp;
        mstatus[`MSTATUS_MPP_LO +: 2] = st_mpp;
    end

    assign priv_mode = cur_mode;

    // The mode comes back from MPP on mret, so this also covers the MPP legalization
    assert property (@(posedge clk) disable iff (!rst_n) cur_mode inside {priv_u, priv_m})
        else $error("Privilege mode holds a reserved encoding");

endmodule

`default_nettype wire

// ==== trap_csrs.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "csr_defs.svh"

module trap_csrs import csr_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  wr_mtvec,
    input  logic  wr_mscratch,
    input  logic  wr_mepc,
    input  logic  wr_mcause,
    input  xlen_t wr_data,
    input  logic  trap_enter,
    input  xlen_t trap_cause,
    input  xlen_t pc,
    output xlen_t mtvec,
    output xlen_t mscratch,
    output xlen_t mepc,
    output xlen_t mcause
);

    // Bit 1 of mtvec is reserved, only direct and vectored modes exist
    localparam xlen_t MTVEC_MASK = ~xlen_t'(2);

    // mepc holds word aligned addresses only
    localparam xlen_t MEPC_MASK = ~xlen_t'(3);

    // mcause keeps the interrupt flag and the exception code
    localparam xlen_t MCAUSE_MASK = {1'b1, {(`XLEN-`CAUSE_W-1){1'b0}}, {`CAUSE_W{1'b1}}};

    // Trap vector base and mode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec <= '0;
        end else if (wr_mtvec) begin
            mtvec <= wr_data & MTVEC_MASK;
        end
    end

    // Scratch register for the trap handler, no legalization
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch <= '0;
        end else if (wr_mscratch) begin
            mscratch <= wr_data;
        end
    end

    // The PC of the trapping instruction wins over a software write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc <= '0;
        end else if (trap_enter) begin
            mepc <= pc & MEPC_MASK;
        end else if (wr_mepc) begin
            mepc <= wr_data & MEPC_MASK;
        end
    end

    // Cause of the last trap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcause <= '0;
        end else if (trap_enter) begin
            mcause <= trap_cause & MCAUSE_MASK;
        end else if (wr_mcause) begin
            mcause <= wr_data & MCAUSE_MASK;
        end
    end

endmodule

`default_nettype wire

// ==== csr_access.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "csr_defs.svh"

module csr_access import csr_pkg::*; (
    input  logic      csr_valid,
    input  csr_op_t   csr_op,
    input  csr_addr_t csr_addr,
    input  xlen_t     csr_wdata,
    input  priv_t     priv_mode,
    input  logic      wr_block,
    input  xlen_t     mstatus,
    input  xlen_t     mie,
    input  xlen_t     mip,
    input  xlen_t     mtvec,
    input  xlen_t     mscratch,
    input  xlen_t     mepc,
    input  xlen_t     mcause,
    output xlen_t     csr_rdata,
    output logic      illegal,
    output xlen_t     wr_data,
    output logic      wr_mstatus,
    output logic      wr_mie,
    output logic      wr_mtvec,
    output logic      wr_mscratch,
    output logic      wr_mepc,
    output logic      wr_mcause
);

    // Value of the addressed CSR before this access
    xlen_t old_val;
    logic  known;
    logic  read_only;
    logic  has_write;
    logic  wr_en;

    // Read mux, mhartid is hart zero
    always_comb begin
        known   = 1'b1;
        old_val = '0;
        case (csr_addr)
            `CSR_MSTATUS:  old_val = mstatus;
            `CSR_MIE:      old_val = mie;
            `CSR_MTVEC:    old_val = mtvec;
            `CSR_MSCRATCH: old_val = mscratch;
            `CSR_MEPC:     old_val = mepc;
            `CSR_MCAUSE:   old_val = mcause;
            `CSR_MIP:      old_val = mip;
            `CSR_MHARTID:  old_val = '0;
            default:       known   = 1'b0;
        endcase
    end

    assign csr_rdata = old_val;

    // The top two address bits mark the read-only CSR space
    assign read_only = (csr_addr[`CSR_ADDR_W-1 -: 2] == 2'b11);

    // Set or clear with zero data only reads, so it is allowed on read-only CSRs
    assign has_write = (csr_op == csr_write) || (csr_wdata != '0);

    // All implemented CSRs are machine level, U-mode may touch none of them
    assign illegal = csr_valid &&
                     (!known || (priv_mode == priv_u) || (read_only && has_write));

    // Read-modify-write value for the three ops
    always_comb begin
        case (csr_op)
            csr_set:   wr_data = old_val | csr_wdata;
            csr_clear: wr_data = old_val & ~csr_wdata;
            default:   wr_data = csr_wdata;
        endcase
    end

    // A trap or mret in the same cycle suppresses the write
    assign wr_en = csr_valid && !illegal && !wr_block;

    // mip and mhartid get no strobe, so writes to mip are dropped
    assign wr_mstatus  = wr_en && (csr_addr == `CSR_MSTATUS);
    assign wr_mie      = wr_en && (csr_addr == `CSR_MIE);
    assign wr_mtvec    = wr_en && (csr_addr == `CSR_MTVEC);
    assign wr_mscratch = wr_en && (csr_addr == `CSR_MSCRATCH);
    assign wr_mepc     = wr_en && (csr_addr == `CSR_MEPC);
    assign wr_mcause   = wr_en && (csr_addr == `CSR_MCAUSE);

endmodule

`default_nettype wire

// ==== trap_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "csr_defs.svh"

module trap_ctrl import csr_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   wr_mie,
    input  xlen_t  wr_data,
    input  logic   irq_ext,
    input  logic   exc_valid,
    input  cause_t exc_cause,
    input  logic   illegal,
    input  logic   mret,
    input  priv_t  priv_mode,
    input  xlen_t  mstatus,
    input  xlen_t  mtvec,
    input  xlen_t  mepc,
    output xlen_t  mie,
    output xlen_t  mip,
    output logic   trap_enter,
    output logic   do_mret,
    output logic   wr_block,
    output xlen_t  trap_cause,
    output xlen_t  redirect_pc
);

    // Only the external interrupt enable is implemented
    logic  meie;
    logic  irq_pending;
    xlen_t trap_base;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meie <= 1'b0;
        end else if (wr_mie) begin
            meie <= wr_data[`MIE_MEIE];
        end
    end

    always_comb begin
        mie = '0;
        mie[`MIE_MEIE] = meie;
        mip = '0;
        mip[`MIE_MEIE] = irq_ext;
    end

    // In U-mode machine interrupts are enabled regardless of mstatus.MIE
    assign irq_pending = irq_ext && meie && ((priv_mode == priv_u) || mstatus[`MSTATUS_MIE]);

    assign trap_enter = exc_valid || illegal || irq_pending;
    assign do_mret    = mret && !trap_enter;
    assign wr_block   = trap_enter || do_mret;

    // Exception first, then illegal CSR access, then the interrupt
    always_comb begin
        trap_cause = '0;
        if (exc_valid) begin
            trap_cause[`CAUSE_W-1:0] = exc_cause;
        end else if (illegal) begin
            trap_cause[`CAUSE_W-1:0] = `CAUSE_W'(`CAUSE_ILLEGAL_INSN);
        end else begin
            trap_cause[`XLEN-1]      = 1'b1;
            trap_cause[`CAUSE_W-1:0] = `CAUSE_W'(`CAUSE_M_EXT_IRQ);
        end
    end

    assign trap_base = {mtvec[`XLEN-1:2], 2'b00};

    // Vectored mode only offsets interrupts while exceptions still use the base
    always_comb begin
        if (trap_enter) begin
            redirect_pc = trap_base;
            if (mtvec[0] && trap_cause[`XLEN-1]) begin
                redirect_pc = trap_base +
                    {{(`XLEN-`CAUSE_W-2){1'b0}}, trap_cause[`CAUSE_W-1:0], 2'b00};
            end
        end else begin
            redirect_pc = mepc;
        end
    end

    // The write strobes come from csr_access and must be held back by wr_block
    assert property (@(posedge clk) disable iff (!rst_n) !(trap_enter && wr_mie))
        else $error("Trap entry coincides with a CSR write to mie");

endmodule

`default_nettype wire

// ==== csr_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      csr_valid,
    input  csr_op_t   csr_op,
    input  csr_addr_t csr_addr,
    input  xlen_t     csr_wdata,
    input  xlen_t     pc,
    input  logic      exc_valid,
    input  cause_t    exc_cause,
    input  logic      irq_ext,
    input  logic      mret,
    output xlen_t     csr_rdata,
    output logic      illegal_csr,
    output logic      trap_taken,
    output logic      redirect_valid,
    output xlen_t     redirect_pc,
    output priv_t     priv_mode
);

    // CSR contents shared between the blocks
    xlen_t mstatus;
    xlen_t mie;
    xlen_t mip;
    xlen_t mtvec;
    xlen_t mscratch;
    xlen_t mepc;
    xlen_t mcause;

    // Write path from the access decoder
    xlen_t wr_data;
    logic  wr_mstatus;
    logic  wr_mie;
    logic  wr_mtvec;
    logic  wr_mscratch;
    logic  wr_mepc;
    logic  wr_mcause;

    // Trap control
    logic  illegal;
    logic  trap_enter;
    logic  do_mret;
    logic  wr_block;
    xlen_t trap_cause;

    mstatus_reg u_mstatus_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_mstatus (wr_mstatus),
        .wr_data    (wr_data),
        .trap_enter (trap_enter),
        .do_mret    (do_mret),
        .priv_mode  (priv_mode),
        .mstatus    (mstatus)
    );

    trap_csrs u_trap_csrs (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_mtvec    (wr_mtvec),
        .wr_mscratch (wr_mscratch),
        .wr_mepc     (wr_mepc),
        .wr_mcause   (wr_mcause),
        .wr_data     (wr_data),
        .trap_enter  (trap_enter),
        .trap_cause  (trap_cause),
        .pc          (pc),
        .mtvec       (mtvec),
        .mscratch    (mscratch),
        .mepc        (mepc),
        .mcause      (mcause)
    );

    csr_access u_csr_access (
        .csr_valid   (csr_valid),
        .csr_op      (csr_op),
        .csr_addr    (csr_addr),
        .csr_wdata   (csr_wdata),
        .priv_mode   (priv_mode),
        .wr_block    (wr_block),
        .mstatus     (mstatus),
        .mie         (mie),
        .mip         (mip),
        .mtvec       (mtvec),
        .mscratch    (mscratch),
        .mepc        (mepc),
        .mcause      (mcause),
        .csr_rdata   (csr_rdata),
        .illegal     (illegal),
        .wr_data     (wr_data),
        .wr_mstatus  (wr_mstatus),
        .wr_mie      (wr_mie),
        .wr_mtvec    (wr_mtvec),
        .wr_mscratch (wr_mscratch),
        .wr_mepc     (wr_mepc),
        .wr_mcause   (wr_mcause)
    );

    trap_ctrl u_trap_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_mie      (wr_mie),
        .wr_data     (wr_data),
        .irq_ext     (irq_ext),
        .exc_valid   (exc_valid),
        .exc_cause   (exc_cause),
        .illegal     (illegal),
        .mret        (mret),
        .priv_mode   (priv_mode),
        .mstatus     (mstatus),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mie         (mie),
        .mip         (mip),
        .trap_enter  (trap_enter),
        .do_mret     (do_mret),
        .wr_block    (wr_block),
        .trap_cause  (trap_cause),
        .redirect_pc (redirect_pc)
    );

    // The core redirects on a trap as well as on mret
    assign illegal_csr    = illegal;
    assign trap_taken     = trap_enter;
    assign redirect_valid = trap_enter || do_mret;

endmodule

`default_nettype wire

// ==== tb_csr_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "csr_defs.svh"

module tb_csr_unit import csr_pkg::*; ();

    localparam int MAX_ROWS = 64;

    // Output check mask, one bit per DUT output
    localparam logic [5:0] CK_RD    = 6'b000001;
    localparam logic [5:0] CK_ILL   = 6'b000010;
    localparam logic [5:0] CK_TRAP  = 6'b000100;
    localparam logic [5:0] CK_RV    = 6'b001000;
    localparam logic [5:0] CK_RPC   = 6'b010000;
    localparam logic [5:0] CK_PRIV  = 6'b100000;
    localparam logic [5:0] CK_FLAGS = CK_ILL | CK_TRAP | CK_RV;
    localparam logic [5:0] CK_ALL   = 6'b111111;

    logic      clk;
    logic      rst_n;
    logic      csr_valid;
    csr_op_t   csr_op;
    csr_addr_t csr_addr;
    xlen_t     csr_wdata;
    xlen_t     pc;
    logic      exc_valid;
    cause_t    exc_cause;
    logic      irq_ext;
    logic      mret;
    xlen_t     csr_rdata;
    logic      illegal_csr;
    logic      trap_taken;
    logic      redirect_valid;
    xlen_t     redirect_pc;
    priv_t     priv_mode;

    // Stimulus half of the table
    string     r_name  [MAX_ROWS];
    logic      r_valid [MAX_ROWS];
    csr_op_t   r_op    [MAX_ROWS];
    csr_addr_t r_addr  [MAX_ROWS];
    xlen_t     r_wdata [MAX_ROWS];
    xlen_t     r_pc    [MAX_ROWS];
    logic      r_exc   [MAX_ROWS];
    cause_t    r_cause [MAX_ROWS];
    logic      r_irq   [MAX_ROWS];
    logic      r_mret  [MAX_ROWS];

    // Expected half of the table and the outputs that each row checks
    xlen_t      e_rdata [MAX_ROWS];
    logic       e_ill   [MAX_ROWS];
    logic       e_trap  [MAX_ROWS];
    logic       e_rv    [MAX_ROWS];
    xlen_t      e_rpc   [MAX_ROWS];
    priv_t      e_priv  [MAX_ROWS];
    logic [5:0] r_chk   [MAX_ROWS];

    int          num_rows;
    logic        table_ready;
    logic [31:0] lfsr_state;
    xlen_t       scratch_model;
    xlen_t       rnd;

    csr_unit dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .csr_valid      (csr_valid),
        .csr_op         (csr_op),
        .csr_addr       (csr_addr),
        .csr_wdata      (csr_wdata),
        .pc             (pc),
        .exc_valid      (exc_valid),
        .exc_cause      (exc_cause),
        .irq_ext        (irq_ext),
        .mret           (mret),
        .csr_rdata      (csr_rdata),
        .illegal_csr    (illegal_csr),
        .trap_taken     (trap_taken),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .priv_mode      (priv_mode)
    );

    always #5 clk = ~clk;

    // Fibonacci LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit of the word
    task automatic rand_word(output xlen_t w);
        int b;
        w = '0;
        for (b = 0; b < `XLEN; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[`XLEN-2:0], lfsr_state[0]};
        end
    endtask

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_xlen(input string name, input string what, input xlen_t exp,
                              input xlen_t act);
        if (act !== exp) begin
            fail_stop($sformatf("[ERROR] %s: %s expected %h actual %h", name, what, exp, act));
        end
    endtask

    task automatic check_priv(input string name, input priv_t exp, input priv_t act);
        if (act !== exp) begin
            fail_stop($sformatf("[ERROR] %s: priv_mode expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            fail_stop($sformatf("[ERROR] %s: %s expected %b actual %b", name, what, exp, act));
        end
    endtask

    task automatic add_row(input string name, input logic valid, input csr_op_t op,
                           input csr_addr_t addr, input xlen_t wdata, input xlen_t pc_v,
                           input logic exc, input cause_t cause, input logic irq,
                           input logic ret, input xlen_t x_rdata, input logic x_ill,
                           input logic x_trap, input logic x_rv, input xlen_t x_rpc,
                           input priv_t x_priv, input logic [5:0] chk);
        r_name[num_rows]  = name;
        r_valid[num_rows] = valid;
        r_op[num_rows]    = op;
        r_addr[num_rows]  = addr;
        r_wdata[num_rows] = wdata;
        r_pc[num_rows]    = pc_v;
        r_exc[num_rows]   = exc;
        r_cause[num_rows] = cause;
        r_irq[num_rows]   = irq;
        r_mret[num_rows]  = ret;
        e_rdata[num_rows] = x_rdata;
        e_ill[num_rows]   = x_ill;
        e_trap[num_rows]  = x_trap;
        e_rv[num_rows]    = x_rv;
        e_rpc[num_rows]   = x_rpc;
        e_priv[num_rows]  = x_priv;
        r_chk[num_rows]   = chk;
        num_rows++;
    endtask

    // A legal CSR access with no other event in the cycle
    task automatic access_row(input string name, input csr_op_t op, input csr_addr_t addr,
                              input xlen_t wdata, input xlen_t x_rdata, input priv_t x_priv);
        add_row(name, 1'b1, op, addr, wdata, 32'h0, 1'b0, 5'd0, 1'b0, 1'b0,
                x_rdata, 1'b0, 1'b0, 1'b0, 32'h0, x_priv, CK_RD | CK_FLAGS | CK_PRIV);
    endtask

    // Exception, interrupt or mret without a CSR access
    task automatic event_row(input string name, input xlen_t pc_v, input logic exc,
                             input cause_t cause, input logic irq, input logic ret,
                             input logic x_trap, input logic x_rv, input xlen_t x_rpc,
                             input priv_t x_priv);
        add_row(name, 1'b0, csr_write, 12'h0, 32'h0, pc_v, exc, cause, irq, ret,
                32'h0, 1'b0, x_trap, x_rv, x_rpc, x_priv,
                CK_FLAGS | CK_PRIV | (x_rv ? CK_RPC : 6'b0));
    endtask

    task automatic apply_row(input int i);
        csr_valid = r_valid[i];
        csr_op    = r_op[i];
        csr_addr  = r_addr[i];
        csr_wdata = r_wdata[i];
        pc        = r_pc[i];
        exc_valid = r_exc[i];
        exc_cause = r_cause[i];
        irq_ext   = r_irq[i];
        mret      = r_mret[i];
    endtask

    task automatic verify_row(input int i);
        if (|(r_chk[i] & CK_RD)) check_xlen(r_name[i], "csr_rdata", e_rdata[i], csr_rdata);
        if (|(r_chk[i] & CK_ILL)) check_flag(r_name[i], "illegal_csr", e_ill[i], illegal_csr);
        if (|(r_chk[i] & CK_TRAP)) check_flag(r_name[i], "trap_taken", e_trap[i], trap_taken);
        if (|(r_chk[i] & CK_RV)) check_flag(r_name[i], "redirect_valid", e_rv[i], redirect_valid);
        if (|(r_chk[i] & CK_RPC)) check_xlen(r_name[i], "redirect_pc", e_rpc[i], redirect_pc);
        if (|(r_chk[i] & CK_PRIV)) check_priv(r_name[i], e_priv[i], priv_mode);
    endtask

    // Fills the table, tracking mscratch so that each readback follows the op rules
    task automatic build_table();
        access_row("reset_mstatus", csr_set, `CSR_MSTATUS, 32'h0, 32'h0, priv_m);
        access_row("read_mhartid", csr_set, `CSR_MHARTID, 32'h0, 32'h0, priv_m);
        // Writing mhartid traps, which also saves M in MPP
        add_row("write_mhartid", 1'b1, csr_write, `CSR_MHARTID, 32'h1, 32'h100, 1'b0, 5'd0,
                1'b0, 1'b0, 32'h0, 1'b1, 1'b1, 1'b1, 32'h0, priv_m, CK_ALL);
        access_row("illegal_mcause", csr_set, `CSR_MCAUSE, 32'h0, 32'h2, priv_m);
        rand_word(rnd);
        access_row("mscratch_write", csr_write, `CSR_MSCRATCH, rnd, scratch_model, priv_m);
        scratch_model = rnd;
        rand_word(rnd);
        access_row("mscratch_set", csr_set, `CSR_MSCRATCH, rnd, scratch_model, priv_m);
        scratch_model = scratch_model | rnd;
        rand_word(rnd);
        access_row("mscratch_clear", csr_clear, `CSR_MSCRATCH, rnd, scratch_model, priv_m);
        scratch_model = scratch_model & ~rnd;
        access_row("mscratch_read", csr_set, `CSR_MSCRATCH, 32'h0, scratch_model, priv_m);
        // Only MEIE is stored in mie
        access_row("mie_write_all", csr_write, `CSR_MIE, 32'hffff_ffff, 32'h0, priv_m);
        access_row("mie_clear", csr_clear, `CSR_MIE, 32'h800, 32'h800, priv_m);
        access_row("mie_set", csr_set, `CSR_MIE, 32'h800, 32'h0, priv_m);
        access_row("mie_read", csr_set, `CSR_MIE, 32'h0, 32'h800, priv_m);
        access_row("mip_write", csr_write, `CSR_MIP, 32'hffff_ffff, 32'h0, priv_m);
        access_row("mip_read", csr_set, `CSR_MIP, 32'h0, 32'h0, priv_m);
        access_row("mtvec_write", csr_write, `CSR_MTVEC, 32'h0000_2003, 32'h0, priv_m);
        access_row("mtvec_bit1", csr_set, `CSR_MTVEC, 32'h0, 32'h0000_2001, priv_m);
        access_row("mpp_01_kept", csr_write, `CSR_MSTATUS, 32'h0800, 32'h1800, priv_m);
        access_row("mpp_10_kept", csr_write, `CSR_MSTATUS, 32'h1000, 32'h1800, priv_m);
        access_row("mstatus_mie_on", csr_write, `CSR_MSTATUS, 32'h0008, 32'h1800, priv_m);
        access_row("mstatus_mie_read", csr_set, `CSR_MSTATUS, 32'h0, 32'h0008, priv_m);
        // Exceptions use the base even in vectored mode
        event_row("exc_trap", 32'h4006, 1'b1, 5'd5, 1'b0, 1'b0, 1'b1, 1'b1, 32'h2000, priv_m);
        access_row("exc_mepc", csr_set, `CSR_MEPC, 32'h0, 32'h4004, priv_m);
        access_row("exc_mcause", csr_set, `CSR_MCAUSE, 32'h0, 32'h5, priv_m);
        access_row("exc_mstatus", csr_set, `CSR_MSTATUS, 32'h0, 32'h1880, priv_m);
        access_row("mpp_to_u", csr_write, `CSR_MSTATUS, 32'h0080, 32'h1880, priv_m);
        event_row("mret_to_u", 32'h0, 1'b0, 5'd0, 1'b0, 1'b1, 1'b0, 1'b1, 32'h4004, priv_m);
        event_row("mode_after_mret", 32'h0, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, priv_u);
        add_row("u_mode_access", 1'b1, csr_set, `CSR_MSCRATCH, 32'h0, 32'h5008, 1'b0, 5'd0,
                1'b0, 1'b0, scratch_model, 1'b1, 1'b1, 1'b1, 32'h2000, priv_u, CK_ALL);
        access_row("u_trap_mepc", csr_set, `CSR_MEPC, 32'h0, 32'h5008, priv_m);
        access_row("u_trap_mcause", csr_set, `CSR_MCAUSE, 32'h0, 32'h2, priv_m);
        access_row("u_trap_mstatus", csr_set, `CSR_MSTATUS, 32'h0, 32'h0080, priv_m);
        // M-mode with MIE clear masks the interrupt, mip still shows it
        add_row("irq_masked_by_mie", 1'b1, csr_set, `CSR_MIP, 32'h0, 32'h0, 1'b0, 5'd0,
                1'b1, 1'b0, 32'h800, 1'b0, 1'b0, 1'b0, 32'h0, priv_m,
                CK_RD | CK_FLAGS | CK_PRIV);
        access_row("meie_off", csr_clear, `CSR_MIE, 32'h800, 32'h800, priv_m);
        access_row("mie_enable", csr_set, `CSR_MSTATUS, 32'h8, 32'h0080, priv_m);
        event_row("irq_masked_by_meie", 32'h0, 1'b0, 5'd0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0,
                  priv_m);
        access_row("meie_on", csr_set, `CSR_MIE, 32'h800, 32'h0, priv_m);
        // Vectored target is base plus four times code 11
        event_row("irq_vectored", 32'h6000, 1'b0, 5'd0, 1'b1, 1'b0, 1'b1, 1'b1, 32'h202c,
                  priv_m);
        access_row("irq_mcause", csr_set, `CSR_MCAUSE, 32'h0, 32'h8000_000b, priv_m);
        access_row("irq_mepc", csr_set, `CSR_MEPC, 32'h0, 32'h6000, priv_m);
        access_row("mie_reenable", csr_set, `CSR_MSTATUS, 32'h8, 32'h1880, priv_m);
        event_row("exc_beats_irq", 32'h7000, 1'b1, 5'd3, 1'b1, 1'b0, 1'b1, 1'b1, 32'h2000,
                  priv_m);
        access_row("exc_beats_mcause", csr_set, `CSR_MCAUSE, 32'h0, 32'h3, priv_m);
        access_row("mstatus_zero", csr_write, `CSR_MSTATUS, 32'h0, 32'h1880, priv_m);
        event_row("mret_again", 32'h0, 1'b0, 5'd0, 1'b0, 1'b1, 1'b0, 1'b1, 32'h7000, priv_m);
        // U-mode takes the interrupt although MIE is clear
        event_row("irq_in_u_mode", 32'h8004, 1'b0, 5'd0, 1'b1, 1'b0, 1'b1, 1'b1, 32'h202c,
                  priv_u);
        access_row("u_irq_mcause", csr_set, `CSR_MCAUSE, 32'h0, 32'h8000_000b, priv_m);
        access_row("u_irq_mstatus", csr_set, `CSR_MSTATUS, 32'h0, 32'h0, priv_m);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        csr_valid     = 1'b0;
        csr_op        = csr_write;
        csr_addr      = '0;
        csr_wdata     = '0;
        pc            = '0;
        exc_valid     = 1'b0;
        exc_cause     = '0;
        irq_ext       = 1'b0;
        mret          = 1'b0;
        num_rows      = 0;
        table_ready   = 1'b0;
        lfsr_state    = 32'h3f8b22b1;
        scratch_model = '0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        // Drive 1 ns after the edge, sample 1 ns before the next one
        for (int i = 0; i < num_rows; i++) begin
            @(posedge clk);
            #1;
            apply_row(i);
            #8;
            verify_row(i);
        end
        $display("Finished with no errors");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (table_ready);
        #(num_rows * 10 + 100);
        fail_stop("Simulation timed out before all rows were applied");
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
csr_pkg.sv
mstatus_reg.sv
trap_csrs.sv
csr_access.sv
trap_ctrl.sv
csr_unit.sv
tb_csr_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run the testbench and look for the pass message in the log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_csr_unit \
    -f sim.f -o sim_tb &&
{ ./obj_dir/sim_tb > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -q "^Finished with no errors$" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
